//--- Bender.yml
package:
  name: synapse

sources:
  - synapse_pkg.sv
  - fetch_control.sv
  - instr_decode.sv
  - result_units.sv
  - source_mux.sv
  - synapse_core.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - tb_synapse.sv

//--- fetch_control.sv
module fetch_control import synapse_pkg::*; (
    input  logic     sysreset,
    input  logic     sysclk,
    input  word_t    code_in,
    input  logic     code_ready,
    input  decoded_t dec,
    input  word_t    src_word,
    input  flags_t   flags,
    output addr_t    code_addr,
    output word_t    exr,
    output logic     exec,
    output word_t    ret_addr
);

    // address of the word now on code_in.
    addr_t ipr;
    addr_t ipr_next;

    // exr holds inline data from an imm16 source.
    logic const_skip;
    // exr holds a branch literal or the word after a return.
    logic branch_skip;
    // code_in holds a word fetched since reset.
    logic code_valid;

    logic [2**flag_sel_width-1:0] flag_vec;
    logic flag_sel;
    logic is_branch;
    logic is_return;
    logic branch_accept;

    assign exec = code_ready && !const_skip && !branch_skip;

    assign is_branch = exec && (dec.op == op_br || dec.op == op_bn);
    assign is_return = exec && (dec.op == op_return);

    // selects above the defined flags read as one.
    // so br with those selects is an unconditional jump.
    assign flag_vec = {{(2**flag_sel_width - $bits(flags_t)){1'b1}}, flags};
    assign flag_sel = flag_vec[dec.src[flag_sel_width-1:0]];

    // the branch target is the word after the branch, already on code_in.
    assign branch_accept = is_branch && ((dec.op == op_br) ? flag_sel : !flag_sel);

    // the next pointer goes straight to the code port.
    // so a taken branch costs one skipped cycle only.
    always_comb begin
        if (branch_accept) begin
            ipr_next = code_in;
        end else if (is_return) begin
            ipr_next = ret_addr;
        end else begin
            ipr_next = ipr + addr_t'(1);
        end
    end

    assign code_addr = ipr_next;

    // reset parks the pointer one below word 0.
    // the pipe then refills as after a jump to word 0.
    always_ff @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            ipr <= '1;
            exr <= '0;
            ret_addr <= '0;
            code_valid <= 1'b0;
            const_skip <= 1'b0;
            branch_skip <= 1'b1;
        end else begin
            if (code_ready) begin
                ipr <= ipr_next;
                exr <= code_in;
                code_valid <= 1'b1;
            end

            // return swaps the pointer and the return address.
            if (is_return) begin
                ret_addr <= ipr;
            end else if (exec && dec.op == op_ld_ret) begin
                ret_addr <= src_word;
            end

            // a branch with an imm16 source skips the same word.
            // only the branch flag is raised for it.
            const_skip <= (exec && dec.imm16 && !is_branch && !is_return)
                || (const_skip && !code_ready);

            // hold each skip until a code_ready cycle consumes it.
            branch_skip <= is_branch || is_return || !code_valid
                || (branch_skip && !code_ready);
        end
    end

    // only one reason to skip the word in exr at any time.
    skip_exclusive: assert property (
        @(posedge sysreset) disable iff (sysclk)
        !(const_skip && branch_skip)
    );

endmodule

//--- instr_decode.sv
module instr_decode import synapse_pkg::*; (
    input  word_t                exr,
    input  logic                 exec,
    output decoded_t             dec,
    output logic [num_regs-1:0]  r_load
);

    dest_t dest;
    src_t src;
    op_e op;

    // destination in the top bits, source in the low bits.
    assign dest = exr[word_width-1 -: dest_width];
    assign src = exr[src_width-1:0];

    // low destination codes address the register file.
    // codes between the file and the control block do nothing.
    always_comb begin
        if (dest < dest_t'(num_regs)) begin
            op = op_reg;
        end else begin
            case (dest)
                dest_clrf:     op = op_clrf;
                dest_setf:     op = op_setf;
                dest_nop:      op = op_nop;
                dest_br:       op = op_br;
                dest_bn:       op = op_bn;
                dest_ret_addr: op = op_ld_ret;
                dest_return:   op = op_return;
                default:       op = op_none;
            endcase
        end
    end

    assign dec = '{
        op:    op,
        dest:  dest,
        src:   src,
        exec:  exec,
        imm16: (src == src_imm16)
    };

    // one strobe for the executed register destination.
    always_comb begin
        r_load = '0;
        if (exec && op == op_reg) begin
            r_load[dest[reg_sel_width-1:0]] = 1'b1;
        end
    end

endmodule

//--- result_units.sv
module result_units import synapse_pkg::*; (
    input  logic      sysreset,
    input  logic      sysclk,
    input  reg_bank_t regs,
    input  decoded_t  dec,
    input  word_t     src_word,
    output word_t     ad0,
    output word_t     and0,
    output word_t     or0,
    output word_t     xor0,
    output word_t     sh1r,
    output word_t     sh1l,
    output word_t     sh4l,
    output word_t     sh4r,
    output flags_t    flags
);

    // r0 and r1 are the operands of every unit here.
    word_t r0;
    word_t r1;
    logic [word_width:0] sum;
    word_t and_comb;
    logic set_cin;
    logic clr_cin;
    // carry into ad0.
    logic cin;
    // carry out of the last registered sum.
    logic cout;

    assign r0 = regs[0];
    assign r1 = regs[1];

    assign sum = {1'b0, r0} + {1'b0, r1} + {{word_width{1'b0}}, cin};
    assign and_comb = r0 & r1;

    // source bit 0 qualifies both flag operators.
    assign set_cin = dec.exec && dec.op == op_setf && src_word[0];
    assign clr_cin = dec.exec && dec.op == op_clrf && src_word[0];

    // result words track the operands every cycle, stalled or not.
    always_ff @(posedge sysreset) begin
        ad0 <= sum[word_width-1:0];
        and0 <= and_comb;
        or0 <= r0 | r1;
        xor0 <= r0 ^ r1;
    end

    always_ff @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            cin <= 1'b0;
            cout <= 1'b0;
        end else begin
            if (set_cin) begin
                cin <= 1'b1;
            end else if (clr_cin) begin
                cin <= 1'b0;
            end
            cout <= sum[word_width];
        end
    end

    // shifts of r0 fill with zeros.
    assign sh1r = {1'b0, r0[word_width-1:1]};
    assign sh1l = {r0[word_width-2:0], 1'b0};
    assign sh4l = {r0[word_width-5:0], 4'h0};
    assign sh4r = {4'h0, r0[word_width-1:4]};

    // unsigned compare of r0 against r1.
    assign flags = '{
        eq:        (r0 == r1),
        gt:        (r0 > r1),
        lt:        (r0 < r1),
        carry:     cout,
        and0_zero: (and_comb == '0),
        z0:        (r0 == '0)
    };

endmodule

//--- source_mux.sv
module source_mux import synapse_pkg::*; (
    input  decoded_t  dec,
    input  reg_bank_t regs,
    input  word_t     ad0,
    input  word_t     and0,
    input  word_t     or0,
    input  word_t     xor0,
    input  word_t     sh1r,
    input  word_t     sh1l,
    input  word_t     sh4l,
    input  word_t     sh4r,
    input  word_t     ret_addr,
    input  word_t     code_in,
    output word_t     src_word
);

    // the register file sits at the bottom of the source space.
    // small constants fill 0x200..0x2ff and single codes fill the rest.
    always_comb begin
        if (dec.src < src_t'(num_regs)) begin
            src_word = regs[dec.src[reg_sel_width-1:0]];
        end else if (dec.src[src_width-1 -: 2] == src_const_blk) begin
            // zero-extended low byte of the instruction.
            src_word = word_t'(dec.src[7:0]);
        end else begin
            case (dec.src)
                src_ret_addr: src_word = ret_addr;
                src_ad0:      src_word = ad0;
                src_and0:     src_word = and0;
                src_or0:      src_word = or0;
                src_xor0:     src_word = xor0;
                src_sh1r:     src_word = sh1r;
                src_sh1l:     src_word = sh1l;
                src_sh4l:     src_word = sh4l;
                src_sh4r:     src_word = sh4r;
                src_neg1:     src_word = '1;
                // the word after the instruction is already on the code port.
                src_imm16:    src_word = code_in;
                default:      src_word = '0;
            endcase
        end
    end

endmodule

//--- sources.f
synapse_pkg.sv
fetch_control.sv
instr_decode.sv
result_units.sv
source_mux.sv
synapse_core.sv
tb_clock_gen.sv
tb_synapse.sv

//--- synapse_core.sv
module synapse_core import synapse_pkg::*; (
    input  logic                sysreset,
    input  logic                sysclk,
    input  word_t               code_in,
    input  logic                code_ready,
    input  reg_bank_t           r,
    output addr_t               code_addr,
    output logic [num_regs-1:0] r_load,
    output word_t               r_load_data
);

    // sysreset clocks the core, sysclk is the asynchronous reset.

    word_t exr;
    logic exec;
    word_t ret_addr;
    decoded_t dec;
    flags_t flags;
    word_t ad0;
    word_t and0;
    word_t or0;
    word_t xor0;
    word_t sh1r;
    word_t sh1l;
    word_t sh4l;
    word_t sh4r;

    // pointer, exr, skip flags and branch decision.
    fetch_control fetch_control_i (
        .sysreset   (sysreset),
        .sysclk     (sysclk),
        .code_in    (code_in),
        .code_ready (code_ready),
        .dec        (dec),
        .src_word   (r_load_data),
        .flags      (flags),
        .code_addr  (code_addr),
        .exr        (exr),
        .exec       (exec),
        .ret_addr   (ret_addr)
    );

    instr_decode instr_decode_i (
        .exr    (exr),
        .exec   (exec),
        .dec    (dec),
        .r_load (r_load)
    );

    result_units result_units_i (
        .sysreset (sysreset),
        .sysclk   (sysclk),
        .regs     (r),
        .dec      (dec),
        .src_word (r_load_data),
        .ad0      (ad0),
        .and0     (and0),
        .or0      (or0),
        .xor0     (xor0),
        .sh1r     (sh1r),
        .sh1l     (sh1l),
        .sh4l     (sh4l),
        .sh4r     (sh4r),
        .flags    (flags)
    );

    // the selected source is also the register write data.
    source_mux source_mux_i (
        .dec      (dec),
        .regs     (r),
        .ad0      (ad0),
        .and0     (and0),
        .or0      (or0),
        .xor0     (xor0),
        .sh1r     (sh1r),
        .sh1l     (sh1l),
        .sh4l     (sh4l),
        .sh4r     (sh4r),
        .ret_addr (ret_addr),
        .code_in  (code_in),
        .src_word (r_load_data)
    );

endmodule

//--- synapse_pkg.sv
package synapse_pkg;

    // data path and code space widths.
    localparam int word_width = 16;
    localparam int ipr_width = 16;

    // an instruction is a destination field above a source field.
    localparam int dest_width = 6;
    localparam int src_width = 10;

    // external register file size, and the index bits that address it.
    localparam int num_regs = 8;
    localparam int reg_sel_width = $clog2(num_regs);

    // the low source bits of br and bn pick one flag.
    localparam int flag_sel_width = 4;

    typedef logic [word_width-1:0] word_t;
    typedef logic [ipr_width-1:0] addr_t;
    typedef logic [dest_width-1:0] dest_t;
    typedef logic [src_width-1:0] src_t;

    // image of the register file as seen by the core.
    typedef logic [num_regs-1:0][word_width-1:0] reg_bank_t;

    // destination codes with side effects.
    // codes below num_regs write the register file.
    localparam dest_t dest_clrf = 6'h30;
    localparam dest_t dest_setf = 6'h31;
    localparam dest_t dest_nop = 6'h32;
    localparam dest_t dest_br = 6'h38;
    localparam dest_t dest_bn = 6'h39;
    localparam dest_t dest_ret_addr = 6'h3e;
    localparam dest_t dest_return = 6'h3f;

    // source codes.
    // the return address sits at the same code as its destination.
    localparam src_t src_ret_addr = 10'h03e;
    localparam src_t src_ad0 = 10'h300;
    localparam src_t src_and0 = 10'h330;
    localparam src_t src_or0 = 10'h334;
    localparam src_t src_xor0 = 10'h338;
    localparam src_t src_sh1r = 10'h350;
    localparam src_t src_sh1l = 10'h351;
    localparam src_t src_sh4l = 10'h352;
    localparam src_t src_sh4r = 10'h353;
    localparam src_t src_neg1 = 10'h360;
    localparam src_t src_imm16 = 10'h3a0;

    // top two source bits of the small constant block 0x200..0x2ff.
    localparam logic [1:0] src_const_blk = 2'h2;

    // meaning of the destination field.
    typedef enum logic [3:0] {
        op_reg,
        op_clrf,
        op_setf,
        op_nop,
        op_br,
        op_bn,
        op_ld_ret,
        op_return,
        op_none
    } op_e;

    // executing instruction after decode.
    typedef struct packed {
        op_e   op;
        dest_t dest;
        src_t  src;
        logic  exec;
        logic  imm16;
    } decoded_t;

    // members run msb first, so z0 lands on bit 0 and each
    // member's bit index is its flag select code.
    typedef struct packed {
        logic eq;
        logic gt;
        logic lt;
        logic carry;
        logic and0_zero;
        logic z0;
    } flags_t;

endpackage

//--- tb_clock_gen.sv
module tb_clock_gen (
    output logic sysreset,
    output logic sysclk
);

    timeunit 1ns;
    timeprecision 1ps;

    // sysreset is the core clock with a 100 ns period.
    initial begin
        sysreset = 1'b0;
        forever begin
            #50 sysreset = ~sysreset;
        end
    end

    // sysclk is the active-high reset, released on a falling edge after 8 cycles.
    initial begin
        sysclk = 1'b1;
        #800 sysclk = 1'b0;
    end

endmodule

//--- tb_synapse.sv
module tb_synapse import synapse_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    logic sysreset;
    logic sysclk;
    word_t code_in;
    logic code_ready;
    reg_bank_t regs;
    addr_t code_addr;
    logic [num_regs-1:0] r_load;
    word_t r_load_data;

    integer seed;
    word_t mem [0:511];
    int unsigned plen;
    int unsigned loop_at;
    int unsigned n_exp;
    int unsigned n_seen;
    logic gen_done;
    logic final_phase;
    logic [2:0] exp_idx [0:1023];
    word_t exp_val [0:1023];
    string exp_tag [0:1023];
    src_t res_src [0:8];

    tb_clock_gen clock_gen_i (
        .sysreset (sysreset),
        .sysclk   (sysclk)
    );

    synapse_core dut_i (
        .sysreset    (sysreset),
        .sysclk      (sysclk),
        .code_in     (code_in),
        .code_ready  (code_ready),
        .r           (regs),
        .code_addr   (code_addr),
        .r_load      (r_load),
        .r_load_data (r_load_data)
    );

    function automatic int unsigned rnd(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic word_t enc(dest_t d, src_t s);
        return {d, s};
    endfunction

    task automatic emit(word_t w);
        mem[plen] = w;
        plen++;
    endtask

    // writes to r0, r1 or the carry-in are followed by one nop.
    task automatic emit_op(dest_t d, src_t s, word_t imm);
        emit(enc(d, s));
        if (s == src_imm16) begin
            emit(imm);
        end
        if (d < 2 || d == dest_setf || d == dest_clrf) begin
            emit(enc(dest_nop, 10'h200));
        end
    endtask

    task automatic build_program();
        int unsigned call_at;
        int unsigned br_at;
        plen = 0;
        call_at = 0;
        res_src = '{src_ad0, src_and0, src_or0, src_xor0, src_sh1r,
                    src_sh1l, src_sh4l, src_sh4r, src_neg1};
        for (int b = 0; b < 30; b++) begin
            if (b == 15) begin
                // the call loads the return address inline and returns into it.
                call_at = plen;
                emit(enc(dest_ret_addr, src_imm16));
                emit('0);
                emit(enc(dest_return, 10'h200));
            end else begin
                case (rnd(6))
                    0: emit_op(dest_t'(rnd(8)), src_t'(rnd(8)), '0);
                    1: emit_op(dest_t'(rnd(8)), src_t'(10'h200 | rnd(256)), '0);
                    2: emit_op(dest_t'(rnd(8)), src_imm16, word_t'($random(seed)));
                    3: emit_op(rnd(2) ? dest_setf : dest_clrf, src_t'(10'h200 | rnd(2)), '0);
                    4: emit_op(dest_t'(rnd(8)), res_src[rnd(9)], '0);
                    default: begin
                        // forward branch over a short path that writes r2..r7.
                        br_at = plen;
                        emit(enc(rnd(2) ? dest_br : dest_bn, src_t'(10'h200 | rnd(16))));
                        emit('0);
                        repeat (1 + rnd(3)) begin
                            emit(enc(dest_t'(2 + rnd(6)), src_t'(10'h200 | rnd(256))));
                        end
                        mem[br_at+1] = word_t'(plen);
                    end
                endcase
            end
        end
        // final self-loop on select 15, which always reads one.
        loop_at = plen;
        emit(enc(dest_br, 10'h20f));
        emit(word_t'(loop_at));
        // subroutine sits behind the loop.
        mem[call_at+1] = word_t'(plen);
        repeat (2) begin
            emit_op(dest_t'(2 + rnd(6)), src_t'(rnd(8)), '0);
        end
        emit(enc(dest_t'(2 + rnd(6)), src_ret_addr));
        emit(enc(dest_return, 10'h200));
    endtask

    // instruction-level model of the move machine.
    task automatic run_model();
        addr_t pc;
        addr_t nxt;
        addr_t ret;
        word_t w;
        word_t v;
        word_t mr [0:num_regs-1];
        logic cin;
        logic [word_width:0] s;
        logic [15:0] fv;
        dest_t d;
        src_t sr;
        string tag;
        int steps;
        pc = '0;
        ret = '0;
        cin = 1'b0;
        n_exp = 0;
        steps = 0;
        for (int i = 0; i < num_regs; i++) begin
            mr[i] = '0;
        end
        while (pc != addr_t'(loop_at) && steps < 2000) begin
            w = mem[pc[8:0]];
            d = w[15:10];
            sr = w[9:0];
            s = {1'b0, mr[0]} + {1'b0, mr[1]} + cin;
            tag = "result read";
            if (sr < 8) begin
                v = mr[sr];
                tag = "register move";
            end else if (sr[9:8] == 2'h2) begin
                v = {8'h00, sr[7:0]};
                tag = "small constant";
            end else begin
                case (sr)
                    src_ad0:      v = s[15:0];
                    src_and0:     v = mr[0] & mr[1];
                    src_or0:      v = mr[0] | mr[1];
                    src_xor0:     v = mr[0] ^ mr[1];
                    src_sh1r:     v = mr[0] >> 1;
                    src_sh1l:     v = mr[0] << 1;
                    src_sh4l:     v = mr[0] << 4;
                    src_sh4r:     v = mr[0] >> 4;
                    src_neg1:     v = 16'hffff;
                    src_imm16:    v = mem[pc[8:0] + 9'd1];
                    src_ret_addr: v = ret;
                    default:      v = '0;
                endcase
                if (sr == src_imm16) tag = "inline immediate";
                if (sr == src_ad0) tag = "adder";
                if (sr == src_ret_addr) tag = "return address";
            end
            // flag select order z0, and0 zero, carry, lt, gt, eq, then ones.
            fv = {10'h3ff, mr[0] == mr[1], mr[0] > mr[1], mr[0] < mr[1], s[16],
                  (mr[0] & mr[1]) == '0, mr[0] == '0};
            nxt = (sr == src_imm16) ? pc + 2 : pc + 1;
            if (d < 8) begin
                exp_idx[n_exp] = d[2:0];
                exp_val[n_exp] = v;
                exp_tag[n_exp] = tag;
                n_exp++;
                mr[d[2:0]] = v;
            end else begin
                case (d)
                    dest_clrf:     if (v[0]) cin = 1'b0;
                    dest_setf:     if (v[0]) cin = 1'b1;
                    dest_br:       nxt = fv[sr[3:0]] ? mem[pc[8:0] + 9'd1] : pc + 2;
                    dest_bn:       nxt = fv[sr[3:0]] ? pc + 2 : mem[pc[8:0] + 9'd1];
                    dest_ret_addr: ret = v;
                    dest_return: begin
                        nxt = ret;
                        ret = pc + 1;
                    end
                    default: ;
                endcase
            end
            pc = nxt;
            steps++;
        end
    endtask

    task automatic check_write(input string name, input logic [num_regs-1:0] exp_load,
                               input word_t exp_data, input logic [num_regs-1:0] act_load,
                               input word_t act_data);
        if (exp_load !== act_load || exp_data !== act_data) begin
            $display("error %s: expected r_load %b data %h, actual r_load %b data %h",
                     name, exp_load, exp_data, act_load, act_data);
            $display("Errors found");
            $fatal(1, "register write mismatch");
        end
    endtask

    task automatic check_pc(input string name, input addr_t exp_addr, input addr_t act_addr);
        if (exp_addr !== act_addr) begin
            $display("error %s: expected %h, actual %h", name, exp_addr, act_addr);
            $display("Errors found");
            $fatal(1, "code address mismatch");
        end
    endtask

    // code memory registers a word on every ready edge.
    always @(posedge sysreset) begin
        if (code_ready) begin
            code_in <= mem[code_addr[8:0]];
        end
    end

    always @(posedge sysreset) begin
        for (int i = 0; i < num_regs; i++) begin
            if (r_load[i]) regs[i] <= r_load_data;
        end
    end

    always @(negedge sysreset) begin
        code_ready <= final_phase ? 1'b1 : (rnd(4) != 0);
    end

    // each write must match the next expected one.
    always @(posedge sysreset) begin
        if (!sysclk && r_load != '0) begin
            if (n_seen >= n_exp) begin
                $display("the core wrote a register after the program had finished");
                $display("Errors found");
                $fatal(1, "extra register write");
            end
            check_write(exp_tag[n_seen], num_regs'(1) << exp_idx[n_seen],
                        exp_val[n_seen], r_load, r_load_data);
            n_seen++;
        end
    end

    initial begin
        wait (gen_done);
        repeat (plen * 4 * 4 + 8) @(posedge sysreset);
        $display("timeout, the program did not finish in time");
        $display("Errors found");
        $fatal(1, "watchdog expired");
    end

    initial begin
        addr_t a;
        addr_t b;
        seed = 32'h42c1;
        code_in = '0;
        code_ready = 1'b0;
        regs = '0;
        n_seen = 0;
        final_phase = 1'b0;
        gen_done = 1'b0;
        for (int i = 0; i < 512; i++) begin
            mem[i] = {dest_nop, 1'b0, 9'(i)};
        end
        build_program();
        run_model();
        gen_done = 1'b1;
        @(negedge sysclk);
        wait (n_seen == n_exp);
        final_phase = 1'b1;
        // run until the core fetches the self-loop.
        do begin
            @(posedge sysreset);
        end while (code_addr !== addr_t'(loop_at));
        @(posedge sysreset);
        a = code_addr;
        @(posedge sysreset);
        b = code_addr;
        // the loop alternates between its branch and its literal.
        check_pc("final loop", addr_t'(loop_at), (a == addr_t'(loop_at)) ? a : b);
        check_pc("final loop next", addr_t'(loop_at + 1), (a == addr_t'(loop_at)) ? b : a);
        $display("No errors");
        $finish;
    end

endmodule
